// File: hdl/mem_test_settings.svh
`ifndef MEM_TEST_SETTINGS_SVH
`define MEM_TEST_SETTINGS_SVH

// one data word on the requester side
`define MEM_TEST_WORD_W 32

// one memory line, stands in for the ddr data path
`define MEM_TEST_LINE_W 128

// words packed into a line
`define MEM_TEST_LANES 4

// lines held by the line memory
`define MEM_TEST_DEPTH_LINES 16

// byte address, covers depth times line bytes
`define MEM_TEST_ADDR_W 8

`endif

// File: hdl/mem_test_pkg.sv
`include "mem_test_settings.svh"

package mem_test_pkg;

	// single data word
	typedef logic [`MEM_TEST_WORD_W-1:0] word_t;

	// full line, lane 0 in the low bits
	typedef logic [`MEM_TEST_LINE_W-1:0] line_t;

	// one strobe per byte of a line
	typedef logic [`MEM_TEST_LINE_W/8-1:0] line_strb_t;

	// byte address
	typedef logic [`MEM_TEST_ADDR_W-1:0] addr_t;

	// word position inside a line
	typedef logic [$clog2(`MEM_TEST_LANES)-1:0] lane_t;

	// one extra bit so a full memory of words fits
	typedef logic [$clog2(`MEM_TEST_DEPTH_LINES * `MEM_TEST_LANES):0] count_t;

	// self-test sequence
	typedef enum logic [2:0] {
		gen_idle,
		gen_write,
		gen_read,
		gen_drain,
		gen_done
	} gen_state_t;

endpackage

// File: hdl/word_bus_if.sv
`include "mem_test_settings.svh"

interface word_bus_if;

	// request channel, single beat
	logic req_valid;
	logic req_ready;
	logic req_write;
	mem_test_pkg::addr_t req_addr;
	mem_test_pkg::word_t req_wdata;

	// read response channel, in request order
	logic rsp_valid;
	logic rsp_ready;
	mem_test_pkg::word_t rsp_rdata;

	// traffic generator side
	modport requester (
		output req_valid, req_write, req_addr, req_wdata, rsp_ready,
		input req_ready, rsp_valid, rsp_rdata
	);

	// width adapter side
	modport completer (
		input req_valid, req_write, req_addr, req_wdata, rsp_ready,
		output req_ready, rsp_valid, rsp_rdata
	);

endinterface

// File: hdl/line_bus_if.sv
`include "mem_test_settings.svh"

interface line_bus_if;

	// request channel, whole line with byte strobes
	logic req_valid;
	logic req_ready;
	logic req_write;
	logic [$clog2(`MEM_TEST_DEPTH_LINES)-1:0] req_line;
	mem_test_pkg::line_t req_wdata;
	mem_test_pkg::line_strb_t req_strb;

	// read response channel
	logic rsp_valid;
	logic rsp_ready;
	mem_test_pkg::line_t rsp_rdata;

	// width adapter side
	modport requester (
		output req_valid, req_write, req_line, req_wdata, req_strb, rsp_ready,
		input req_ready, rsp_valid, rsp_rdata
	);

	// line memory side
	modport completer (
		input req_valid, req_write, req_line, req_wdata, req_strb, rsp_ready,
		output req_ready, rsp_valid, rsp_rdata
	);

endinterface

// File: hdl/mem_test_gen.sv
module mem_test_gen (
	input logic init_calib_complete,
	input logic sys_resetn,
	input logic start,
	input mem_test_pkg::word_t seed,
	input mem_test_pkg::count_t word_count,
	word_bus_if.requester bus,
	output logic [3:0] led,
	output mem_test_pkg::count_t error_count,
	output mem_test_pkg::word_t last_rdata
);

	mem_test_pkg::gen_state_t state;
	mem_test_pkg::word_t seed_q;
	mem_test_pkg::count_t count_q;
	mem_test_pkg::count_t req_idx;
	mem_test_pkg::count_t rsp_idx;
	mem_test_pkg::word_t expected;
	logic req_valid_q;
	logic start_take;
	logic req_fire;
	logic rsp_fire;
	logic req_last;
	logic rsp_last;

	// word i carries seed xor i copied into every byte
	function automatic mem_test_pkg::word_t pattern(input mem_test_pkg::word_t s,
			input mem_test_pkg::count_t idx);
		logic [7:0] b;
		b = 8'(idx);
		return s ^ {($bits(mem_test_pkg::word_t) / 8){b}};
	endfunction

	// start only counts when no run is active
	assign start_take = start
		&& (state == mem_test_pkg::gen_idle || state == mem_test_pkg::gen_done);
	assign req_fire = bus.req_valid && bus.req_ready;
	assign rsp_fire = bus.rsp_valid && bus.rsp_ready;
	assign req_last = req_idx == count_q - 1'b1;
	assign rsp_last = rsp_idx == count_q - 1'b1;
	assign expected = pattern(seed_q, rsp_idx);

	// request side, word i at byte address 4*i
	assign bus.req_valid = req_valid_q;
	assign bus.req_write = state == mem_test_pkg::gen_write;
	assign bus.req_addr = mem_test_pkg::addr_t'({req_idx, 2'b00});
	assign bus.req_wdata = pattern(seed_q, req_idx);
	// checker never stalls the read data
	assign bus.rsp_ready = 1'b1;

	always_ff @(posedge init_calib_complete) begin
		if (start_take) begin
			seed_q <= seed;
		end
	end

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			state <= mem_test_pkg::gen_idle;
			count_q <= '0;
			req_idx <= '0;
			rsp_idx <= '0;
			req_valid_q <= 1'b0;
			error_count <= '0;
			last_rdata <= '0;
		end else begin
			case (state)
				mem_test_pkg::gen_idle, mem_test_pkg::gen_done: begin
					if (start) begin
						// zero words means a full 64-word sweep
						count_q <= (word_count == '0) ?
							mem_test_pkg::count_t'(64) : word_count;
						req_idx <= '0;
						rsp_idx <= '0;
						error_count <= '0;
						req_valid_q <= 1'b1;
						state <= mem_test_pkg::gen_write;
					end
				end
				mem_test_pkg::gen_write: begin
					if (req_fire) begin
						if (req_last) begin
							// valid stays up, next beat is read of word 0
							req_idx <= '0;
							state <= mem_test_pkg::gen_read;
						end else begin
							req_idx <= req_idx + 1'b1;
						end
					end
				end
				mem_test_pkg::gen_read: begin
					if (req_fire) begin
						if (req_last) begin
							req_valid_q <= 1'b0;
							state <= mem_test_pkg::gen_drain;
						end else begin
							req_idx <= req_idx + 1'b1;
						end
					end
				end
				mem_test_pkg::gen_drain: begin
					// wait for the reads still in flight
					if (rsp_fire && rsp_last) begin
						state <= mem_test_pkg::gen_done;
					end
				end
				default: begin
					state <= mem_test_pkg::gen_idle;
				end
			endcase

			// compare each readback against its expected word
			if (rsp_fire) begin
				rsp_idx <= rsp_idx + 1'b1;
				last_rdata <= bus.rsp_rdata;
				if (bus.rsp_rdata != expected) begin
					error_count <= error_count + 1'b1;
				end
			end
		end
	end

	// busy, done, pass, error seen
	assign led[0] = state inside {mem_test_pkg::gen_write, mem_test_pkg::gen_read,
		mem_test_pkg::gen_drain};
	assign led[1] = state == mem_test_pkg::gen_done;
	assign led[2] = state == mem_test_pkg::gen_done && error_count == '0;
	assign led[3] = error_count != '0;

	// stalled request keeps its payload until taken
	a_req_hold: assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		bus.req_valid && !bus.req_ready |=> bus.req_valid && $stable(bus.req_write)
			&& $stable(bus.req_addr) && $stable(bus.req_wdata));

	// memory must not answer once the run is idle
	a_no_rsp_idle: assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		bus.rsp_valid |-> state != mem_test_pkg::gen_idle);

endmodule

// File: hdl/axi_width_adapter.sv
module axi_width_adapter (
	input logic init_calib_complete,
	input logic sys_resetn,
	word_bus_if.completer word_side,
	line_bus_if.requester line_side
);

	localparam int word_w = $bits(mem_test_pkg::word_t);
	localparam int lane_bytes = word_w / 8;
	localparam int lanes = $bits(mem_test_pkg::line_t) / word_w;
	localparam int byte_off_w = $clog2(lane_bytes);
	localparam int line_lsb = byte_off_w + $bits(mem_test_pkg::lane_t);

	mem_test_pkg::lane_t req_lane;
	// lanes of reads still waiting for their line
	mem_test_pkg::lane_t lane_q [2];
	logic wr_ptr;
	logic rd_ptr;
	logic [1:0] q_count;
	logic q_full;
	logic q_empty;
	logic push;
	logic pop;

	// byte address splits into line index, lane and byte offset
	assign req_lane = word_side.req_addr[byte_off_w +: $bits(mem_test_pkg::lane_t)];
	assign line_side.req_line = word_side.req_addr[$bits(mem_test_pkg::addr_t)-1:line_lsb];

	assign q_full = q_count == 2'd2;
	assign q_empty = q_count == 2'd0;

	// requests pass straight through unless the queue is full
	assign line_side.req_valid = word_side.req_valid && !q_full;
	assign word_side.req_ready = line_side.req_ready && !q_full;
	assign line_side.req_write = word_side.req_write;

	// word copied to every lane and the strobes pick the one that lands
	assign line_side.req_wdata = {lanes{word_side.req_wdata}};
	always_comb begin
		line_side.req_strb = '0;
		line_side.req_strb[req_lane * lane_bytes +: lane_bytes] = '1;
	end

	assign push = line_side.req_valid && line_side.req_ready && !line_side.req_write;
	assign pop = line_side.rsp_valid && line_side.rsp_ready;

	// response lane comes from the oldest queued read
	assign word_side.rsp_valid = line_side.rsp_valid;
	assign line_side.rsp_ready = word_side.rsp_ready;
	assign word_side.rsp_rdata = line_side.rsp_rdata[lane_q[rd_ptr] * word_w +: word_w];

	always_ff @(posedge init_calib_complete) begin
		if (push) begin
			lane_q[wr_ptr] <= req_lane;
		end
	end

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			q_count <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= !wr_ptr;
			end
			if (pop) begin
				rd_ptr <= !rd_ptr;
			end
			// push and pop together leave the count alone
			case ({push, pop})
				2'b10: q_count <= q_count + 2'd1;
				2'b01: q_count <= q_count - 2'd1;
				default: q_count <= q_count;
			endcase
		end
	end

	// every line from memory matches a read sent earlier
	a_rsp_queued: assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		line_side.rsp_valid |-> !q_empty);

	// count never passes two and tracks the pointer gap
	a_push_room: assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		q_count <= 2'd2 && q_count[0] == (wr_ptr ^ rd_ptr));

endmodule

// File: hdl/line_memory.sv
`include "mem_test_settings.svh"

module line_memory (
	input logic init_calib_complete,
	input logic sys_resetn,
	line_bus_if.completer bus
);

	mem_test_pkg::line_t mem [`MEM_TEST_DEPTH_LINES];
	mem_test_pkg::line_t rsp_data;
	logic rsp_held;
	logic wr_fire;
	logic rd_fire;

	// one response slot, new read only once the old one leaves
	assign bus.req_ready = !rsp_held || bus.rsp_ready;
	assign wr_fire = bus.req_valid && bus.req_ready && bus.req_write;
	assign rd_fire = bus.req_valid && bus.req_ready && !bus.req_write;

	assign bus.rsp_valid = rsp_held;
	assign bus.rsp_rdata = rsp_data;

	// storage and read register
	always_ff @(posedge init_calib_complete) begin
		if (wr_fire) begin
			// byte lanes only where strobed
			for (int b = 0; b < `MEM_TEST_LINE_W / 8; b++) begin
				if (bus.req_strb[b]) begin
					mem[bus.req_line][b*8 +: 8] <= bus.req_wdata[b*8 +: 8];
				end
			end
		end
		if (rd_fire) begin
			rsp_data <= mem[bus.req_line];
		end
	end

	always_ff @(posedge init_calib_complete or negedge sys_resetn) begin
		if (!sys_resetn) begin
			rsp_held <= 1'b0;
		end else if (rd_fire) begin
			rsp_held <= 1'b1;
		end else if (bus.rsp_ready) begin
			rsp_held <= 1'b0;
		end
	end

	// a write always touches at least one byte
	a_strb_set: assert property (@(posedge init_calib_complete) disable iff (!sys_resetn)
		bus.req_valid && bus.req_write |-> bus.req_strb != '0);

endmodule

// File: hdl/mem_test_top.sv
module mem_test_top (
	input logic init_calib_complete,
	input logic sys_resetn,
	input logic start,
	input mem_test_pkg::word_t seed,
	input mem_test_pkg::count_t word_count,
	output logic [3:0] led,
	output mem_test_pkg::count_t error_count,
	output mem_test_pkg::word_t last_rdata
);

	// generator to adapter, 32-bit words
	word_bus_if word_bus ();
	// adapter to memory, 128-bit lines
	line_bus_if line_bus ();

	// pattern writer, reader and checker
	mem_test_gen i_gen (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.start(start),
		.seed(seed),
		.word_count(word_count),
		.bus(word_bus.requester),
		.led(led),
		.error_count(error_count),
		.last_rdata(last_rdata)
	);

	// 32 to 128 lane steering
	axi_width_adapter i_adapter (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.word_side(word_bus.completer),
		.line_side(line_bus.requester)
	);

	// stand-in for the ddr controller
	line_memory i_mem (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.bus(line_bus.completer)
	);

endmodule

// File: testbench/tb_mem_test.sv
module tb_mem_test;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_rows = 5;
	localparam int timeout_cycles = 2000;

	logic init_calib_complete;
	logic sys_resetn;
	logic start;
	mem_test_pkg::word_t seed;
	mem_test_pkg::count_t word_count;
	logic [3:0] led;
	mem_test_pkg::count_t error_count;
	mem_test_pkg::word_t last_rdata;

	// stimulus and expected final state per run
	mem_test_pkg::word_t seed_tab [num_rows];
	mem_test_pkg::count_t count_tab [num_rows];
	logic [3:0] led_tab [num_rows];
	mem_test_pkg::count_t err_tab [num_rows];

	mem_test_top i_dut (
		.init_calib_complete(init_calib_complete),
		.sys_resetn(sys_resetn),
		.start(start),
		.seed(seed),
		.word_count(word_count),
		.led(led),
		.error_count(error_count),
		.last_rdata(last_rdata)
	);

	// 4 ns clock
	initial begin
		init_calib_complete = 1'b0;
		forever #2 init_calib_complete = ~init_calib_complete;
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	function automatic mem_test_pkg::word_t lfsr_word(input logic [31:0] init);
		logic [31:0] s;
		mem_test_pkg::word_t w;
		s = init;
		w = '0;
		for (int i = 0; i < 32; i++) begin
			s = lfsr_next(s);
			w = {w[30:0], s[0]};
		end
		return w;
	endfunction

	// seed xor index of the final word in every byte
	function automatic mem_test_pkg::word_t last_word(input mem_test_pkg::word_t s,
			input mem_test_pkg::count_t n);
		int words;
		logic [7:0] b;
		words = (n == '0) ? 64 : int'(n);
		b = 8'(words - 1);
		return s ^ {4{b}};
	endfunction

	task automatic stop_with_failure(input string why);
		$display("Simulation FAILED");
		$fatal(1, why);
	endtask

	task automatic check_word(input string name, input mem_test_pkg::word_t got,
			input mem_test_pkg::word_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("word mismatch");
		end
	endtask

	task automatic check_count(input string name, input mem_test_pkg::count_t got,
			input mem_test_pkg::count_t exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("count mismatch");
		end
	endtask

	task automatic check_leds(input string name, input logic [3:0] got,
			input logic [3:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%h expected 0x%h", name, got, exp);
			stop_with_failure("led mismatch");
		end
	endtask

	// 1, 4, 5 and 64 words, then 64 again over the same lines
	task automatic load_table();
		seed_tab[0] = 32'hdead_beef;
		count_tab[0] = 7'd1;
		seed_tab[1] = 32'h1234_5678;
		count_tab[1] = 7'd4;
		seed_tab[2] = lfsr_word(32'h2814_67c3);
		count_tab[2] = 7'd5;
		seed_tab[3] = 32'hffff_0000;
		count_tab[3] = 7'd0;
		seed_tab[4] = 32'h0f0f_a5a5;
		count_tab[4] = 7'd0;
		for (int r = 0; r < num_rows; r++) begin
			// done and pass, nothing else
			led_tab[r] = 4'b0110;
			err_tab[r] = '0;
		end
	endtask

	// busy only until done rises
	task automatic wait_done(input int row);
		int cycles;
		cycles = 0;
		@(negedge init_calib_complete);
		while (led[1] !== 1'b1) begin
			check_leds("led", led, 4'b0001);
			if (cycles == timeout_cycles) begin
				$display("done never came within %0d cycles on row %0d", timeout_cycles, row);
				stop_with_failure("timeout waiting for done");
			end
			cycles++;
			@(negedge init_calib_complete);
		end
	endtask

	initial begin
		sys_resetn = 1'b0;
		start = 1'b0;
		seed = '0;
		word_count = '0;
		load_table();

		repeat (2) @(posedge init_calib_complete);
		sys_resetn <= 1'b1;

		// everything quiet out of reset
		@(negedge init_calib_complete);
		check_leds("led", led, 4'b0000);
		check_count("error_count", error_count, '0);
		check_word("last_rdata", last_rdata, '0);

		for (int r = 0; r < num_rows; r++) begin
			// one-cycle start pulse
			@(posedge init_calib_complete);
			start <= 1'b1;
			seed <= seed_tab[r];
			word_count <= count_tab[r];
			@(posedge init_calib_complete);
			start <= 1'b0;
			wait_done(r);
			check_leds("led", led, led_tab[r]);
			check_count("error_count", error_count, err_tab[r]);
			check_word("last_rdata", last_rdata, last_word(seed_tab[r], count_tab[r]));
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/mem_test_pkg.sv
hdl/word_bus_if.sv
hdl/line_bus_if.sv
hdl/mem_test_gen.sv
hdl/axi_width_adapter.sv
hdl/line_memory.sv
hdl/mem_test_top.sv
testbench/tb_mem_test.sv

// File: Bender.yml
package:
  name: mem_test

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mem_test_pkg.sv
      - hdl/word_bus_if.sv
      - hdl/line_bus_if.sv
      - hdl/mem_test_gen.sv
      - hdl/axi_width_adapter.sv
      - hdl/line_memory.sv
      - hdl/mem_test_top.sv
  - target: simulation
    files:
      - testbench/tb_mem_test.sv
